/* logic/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  // Instruction and register index widths
  localparam int INSN_W     = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_IMM    = 7'b001_0011,
    OPC_ALSU   = 7'b011_0011,
    OPC_SYSTEM = 7'b111_0011
  } opcode_t;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  // funct7 picks ADD or SUB
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // Immediate layouts
  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J
  } imm_kind_t;

endpackage

/* logic/core_pkg.sv */
package core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  localparam logic [XLEN-1:0] RESET_ADDR = '0;

  // ADDI x0, x0, 0 fills squashed fetch slots
  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

  // ALU_ADD sits at zero so a cleared control word is harmless
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LTS,
    ALU_GES
  } alu_op_t;

  // Decoded control where all zero means a bubble
  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    is_branch;
    logic    is_jump;
    logic    jump_reg_base;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    halt;
  } ctrl_t;

endpackage

/* logic/id_ex_if.sv */
`timescale 1ns/10ps

interface id_ex_if import core_pkg::*, riscv_isa_pkg::*; ();

  ctrl_t                 ctrl;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rd;
  // Source indices, zero when the operand is unused
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;

  modport decode_mp (
    output ctrl, pc, rs1_data, rs2_data, imm, rd, rs1, rs2
  );

  modport execute_mp (
    input ctrl, pc, rs1_data, rs2_data, imm, rd, rs1, rs2
  );

endinterface

/* logic/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import core_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] target_pc_i,
  input  logic            halt_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  output logic [XLEN-1:0] instr_addr_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] instr_o
);

  logic [XLEN-1:0] pc_p, pc_n;
  logic [XLEN-1:0] if_pc_p;
  logic [XLEN-1:0] if_instr_p;

  // Halt wins over redirect and the PC step
  always_comb begin
    if (halt_i) begin
      pc_n = pc_p;
    end else if (redirect_i) begin
      pc_n = target_pc_i;
    end else begin
      pc_n = pc_p + XLEN'(4);
    end
  end

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      pc_p       <= RESET_ADDR;
      if_instr_p <= NOP_WORD;
    end else begin
      pc_p       <= pc_n;
      // Word fetched under a redirect belongs to the wrong path
      if_instr_p <= redirect_i ? NOP_WORD : instr_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if_pc_p <= pc_p;
  end

  assign instr_addr_o = pc_p;
  assign pc_o         = if_pc_p;
  assign instr_o      = if_instr_p;

  pc_aligned_a: assert property (
    @(posedge clk_i) disable iff (reset_i) pc_p[1:0] == 2'b00
  );

endmodule

/* logic/register_file.sv */
`timescale 1ns/10ps

module register_file import core_pkg::*, riscv_isa_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic [XLEN-1:0]       wd_i
);

  logic [XLEN-1:0] regs_p [NUM_REGS];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_p[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs_p[rd_i] <= wd_i;
    end
  end

  // Combinational read ports
  assign rs1_data_o = regs_p[rs1_i];
  assign rs2_data_o = regs_p[rs2_i];

  x0_zero_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ((rs1_i == '0) |-> (rs1_data_o == '0)) and ((rs2_i == '0) |-> (rs2_data_o == '0))
  );

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage import core_pkg::*, riscv_isa_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic                  redirect_i,
  input  logic                  halt_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]       wb_data_i,
  id_ex_if.decode_mp            id_ex
);

  logic [INSN_W-1:0]     insn;
  opcode_t               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd, rs1_field, rs2_field;
  logic                  rs1_used, rs2_used, illegal;
  imm_kind_t             imm_kind;
  ctrl_t                 ctrl_n;
  logic [XLEN-1:0]       imm_n;
  logic [XLEN-1:0]       rs1_val, rs2_val;

  //##################################################
  // Field extraction
  //##################################################
  assign insn      = instr_i;
  assign opcode    = opcode_t'(insn[6:0]);
  assign funct3    = insn[14:12];
  assign funct7    = insn[31:25];
  assign rd        = insn[11:7];
  assign rs1_field = insn[19:15];
  assign rs2_field = insn[24:20];

  assign rs1_o = rs1_used ? rs1_field : '0;
  assign rs2_o = rs2_used ? rs2_field : '0;

  //##################################################
  // Control decode
  //##################################################
  always_comb begin
    ctrl_n   = '0;
    imm_kind = IMM_I;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    illegal  = 1'b0;

    case (opcode)
      OPC_JAL: begin
        imm_kind         = IMM_J;
        ctrl_n.is_jump   = 1'b1;
        ctrl_n.reg_write = 1'b1;
      end
      OPC_JALR: begin
        rs1_used             = 1'b1;
        ctrl_n.is_jump       = 1'b1;
        ctrl_n.jump_reg_base = 1'b1;
        ctrl_n.reg_write     = 1'b1;
      end
      OPC_BRANCH: begin
        imm_kind         = IMM_B;
        rs1_used         = 1'b1;
        rs2_used         = 1'b1;
        ctrl_n.is_branch = 1'b1;
        case (funct3)
          F3_BEQ:  ctrl_n.alu_op = ALU_EQ;
          F3_BNE:  ctrl_n.alu_op = ALU_NE;
          F3_BLT:  ctrl_n.alu_op = ALU_LTS;
          F3_BGE:  ctrl_n.alu_op = ALU_GES;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        rs1_used          = 1'b1;
        ctrl_n.use_imm    = 1'b1;
        ctrl_n.mem_read   = 1'b1;
        ctrl_n.mem_to_reg = 1'b1;
        ctrl_n.reg_write  = 1'b1;
      end
      OPC_STORE: begin
        imm_kind         = IMM_S;
        rs1_used         = 1'b1;
        rs2_used         = 1'b1;
        ctrl_n.use_imm   = 1'b1;
        ctrl_n.mem_write = 1'b1;
      end
      OPC_IMM: begin
        rs1_used         = 1'b1;
        ctrl_n.use_imm   = 1'b1;
        ctrl_n.reg_write = 1'b1;
        // ADDI only
        if (funct3 != F3_ADD) begin
          illegal = 1'b1;
        end
      end
      OPC_ALSU: begin
        rs1_used         = 1'b1;
        rs2_used         = 1'b1;
        ctrl_n.reg_write = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD}: ctrl_n.alu_op = ALU_ADD;
          {F7_ALT,  F3_ADD}: ctrl_n.alu_op = ALU_SUB;
          {F7_BASE, F3_XOR}: ctrl_n.alu_op = ALU_XOR;
          {F7_BASE, F3_OR }: ctrl_n.alu_op = ALU_OR;
          {F7_BASE, F3_AND}: ctrl_n.alu_op = ALU_AND;
          default:           illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        if (insn == EBREAK_WORD) begin
          ctrl_n.halt = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    // Unknown words, squashed slots and a halted core all become bubbles
    if (illegal || redirect_i || halt_i) begin
      ctrl_n   = '0;
      rs1_used = 1'b0;
      rs2_used = 1'b0;
    end
  end

  // Immediate generation
  always_comb begin
    case (imm_kind)
      IMM_S:   imm_n = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      IMM_B:   imm_n = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      IMM_J:   imm_n = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      default: imm_n = {{20{insn[31]}}, insn[31:20]};
    endcase
  end

  // Write-back value bypasses the register file write of this cycle
  assign rs1_val = (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == rs1_o)) ? wb_data_i : rs1_data_i;
  assign rs2_val = (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == rs2_o)) ? wb_data_i : rs2_data_i;

  //##################################################
  // Decode/execute register
  //##################################################
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.ctrl <= ctrl_n;
    end
  end

  always_ff @(posedge clk_i) begin
    id_ex.pc       <= pc_i;
    id_ex.rs1_data <= rs1_val;
    id_ex.rs2_data <= rs2_val;
    id_ex.imm      <= imm_n;
    id_ex.rd       <= rd;
    id_ex.rs1      <= rs1_o;
    id_ex.rs2      <= rs2_o;
  end

endmodule

/* logic/alu.sv */
`timescale 1ns/10ps

module alu import core_pkg::*; (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_t         op_i,
  output logic [XLEN-1:0] result_o,
  output logic            branch_taken_o
);

  always_comb begin
    result_o       = '0;
    branch_taken_o = 1'b0;

    case (op_i)
      // Arithmetic and logic
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_AND: result_o = a_i & b_i;

      // Branch compares drive only the flag
      ALU_EQ:  branch_taken_o = (a_i == b_i);
      ALU_NE:  branch_taken_o = (a_i != b_i);
      ALU_LTS: branch_taken_o = ($signed(a_i) < $signed(b_i));
      ALU_GES: branch_taken_o = ($signed(a_i) >= $signed(b_i));
    endcase
  end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import core_pkg::*, riscv_isa_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  id_ex_if.execute_mp           id_ex,
  input  logic [XLEN-1:0]       data_rdata_i,
  output logic [XLEN-1:0]       data_addr_o,
  output logic [XLEN-1:0]       data_wdata_o,
  output logic                  data_re_o,
  output logic                  data_we_o,
  output logic                  redirect_o,
  output logic [XLEN-1:0]       target_pc_o,
  output logic                  halt_o,
  output logic                  wb_we_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  logic [XLEN-1:0]       op_a, rs2_val, op_b;
  logic [XLEN-1:0]       alu_result, target_sum;
  logic                  alu_taken, redirect_n;

  ctrl_t                 ex_ctrl_p;
  logic                  redirect_p;
  logic [XLEN-1:0]       ex_result_p, ex_target_p, ex_store_p, ex_pc_p;
  logic [REG_ADDR_W-1:0] ex_rd_p;

  //##################################################
  // Operands
  //##################################################

  // Second bypass point for the instruction one slot behind write-back
  assign op_a = (wb_we_o && (wb_rd_o != '0) && (wb_rd_o == id_ex.rs1)) ?
                wb_data_o : id_ex.rs1_data;
  assign rs2_val = (wb_we_o && (wb_rd_o != '0) && (wb_rd_o == id_ex.rs2)) ?
                   wb_data_o : id_ex.rs2_data;
  assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;

  alu u_alu (
    .a_i            (op_a),
    .b_i            (op_b),
    .op_i           (id_ex.ctrl.alu_op),
    .result_o       (alu_result),
    .branch_taken_o (alu_taken)
  );

  // JALR is based on rs1, branches and JAL on the PC
  assign target_sum = (id_ex.ctrl.jump_reg_base ? op_a : id_ex.pc) + id_ex.imm;
  assign redirect_n = id_ex.ctrl.is_jump | (id_ex.ctrl.is_branch & alu_taken);

  //##################################################
  // Execute/write-back register
  //##################################################
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      ex_ctrl_p  <= '0;
      redirect_p <= 1'b0;
    end else if (redirect_o) begin
      // Wrong-path instruction behind a taken branch
      ex_ctrl_p  <= '0;
      redirect_p <= 1'b0;
    end else if (!halt_o) begin
      ex_ctrl_p  <= id_ex.ctrl;
      redirect_p <= redirect_n;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_result_p <= alu_result;
    ex_target_p <= {target_sum[XLEN-1:1], 1'b0};
    ex_store_p  <= rs2_val;
    ex_rd_p     <= id_ex.rd;
    ex_pc_p     <= id_ex.pc;
  end

  assign redirect_o  = redirect_p;
  assign target_pc_o = ex_target_p;
  assign halt_o      = ex_ctrl_p.halt;

  // Data memory strobes
  assign data_addr_o  = ex_result_p;
  assign data_wdata_o = ex_store_p;
  assign data_re_o    = ex_ctrl_p.mem_read;
  assign data_we_o    = ex_ctrl_p.mem_write;

  // Write-back select
  assign wb_we_o = ex_ctrl_p.reg_write;
  assign wb_rd_o = ex_rd_p;

  always_comb begin
    if (ex_ctrl_p.is_jump) begin
      wb_data_o = ex_pc_p + XLEN'(4);
    end else if (ex_ctrl_p.mem_to_reg) begin
      wb_data_o = data_rdata_i;
    end else begin
      wb_data_o = ex_result_p;
    end
  end

  mem_strobe_excl_a: assert property (
    @(posedge clk_i) disable iff (reset_i) !(data_re_o && data_we_o)
  );

  // Decode turns the slot behind a redirect into a bubble
  younger_squashed_a: assert property (
    @(posedge clk_i) disable iff (reset_i) redirect_o |=> (id_ex.ctrl == '0)
  );

endmodule

/* logic/micro_riscv_top.sv */
`timescale 1ns/10ps

module micro_riscv_top import core_pkg::*, riscv_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  output logic [XLEN-1:0] data_addr_o,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic [XLEN-1:0] data_wdata_o,
  output logic            data_re_o,
  output logic            data_we_o,
  output logic            finish_o
);

  logic [XLEN-1:0]       if_pc, if_instr;
  logic                  redirect, halt;
  logic [XLEN-1:0]       target_pc;
  logic [REG_ADDR_W-1:0] rs1_idx, rs2_idx;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  id_ex_if id_ex ();

  fetch_stage u_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .redirect_i    (redirect),
    .target_pc_i   (target_pc),
    .halt_i        (halt),
    .instr_rdata_i (instr_rdata_i),
    .instr_addr_o  (instr_addr_o),
    .pc_o          (if_pc),
    .instr_o       (if_instr)
  );

  register_file u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (rs1_idx),
    .rs2_i      (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we),
    .rd_i       (wb_rd),
    .wd_i       (wb_data)
  );

  decode_stage u_decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pc_i       (if_pc),
    .instr_i    (if_instr),
    .redirect_i (redirect),
    .halt_i     (halt),
    .rs1_o      (rs1_idx),
    .rs2_o      (rs2_idx),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .wb_we_i    (wb_we),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data),
    .id_ex      (id_ex.decode_mp)
  );

  execute_stage u_execute (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_ex        (id_ex.execute_mp),
    .data_rdata_i (data_rdata_i),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .data_re_o    (data_re_o),
    .data_we_o    (data_we_o),
    .redirect_o   (redirect),
    .target_pc_o  (target_pc),
    .halt_o       (halt),
    .wb_we_o      (wb_we),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // EBREAK held in write-back keeps this high until reset
  assign finish_o = halt;

endmodule

/* verification/micro_riscv_tb.sv */
`timescale 1ns/10ps

module micro_riscv_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int HALT_CYCLES  = 10;
  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 64;
  localparam int MAX_STORES   = 16;

  logic        clk;
  logic        reset;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic [31:0] data_addr;
  logic [31:0] data_rdata;
  logic [31:0] data_wdata;
  logic        data_re;
  logic        data_we;
  logic        finish;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];

  // Expected store sequence from the stimulus file
  logic [31:0] exp_addr [MAX_STORES];
  logic [31:0] exp_data [MAX_STORES];
  string       exp_name [MAX_STORES];
  int          num_stores  = 0;
  int          store_count = 0;
  int          prog_words  = 0;

  micro_riscv_top uut (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_addr_o  (instr_addr),
    .instr_rdata_i (instr_rdata),
    .data_addr_o   (data_addr),
    .data_rdata_i  (data_rdata),
    .data_wdata_o  (data_wdata),
    .data_re_o     (data_re),
    .data_we_o     (data_we),
    .finish_o      (finish)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //##################################################
  // Memory models
  //##################################################
  assign instr_rdata = imem[instr_addr[7:2]];
  // Read data is garbage unless the load strobe is up
  assign data_rdata  = data_re ? dmem[data_addr[7:2]] : 32'hBAD0_BAD0;

  always @(posedge clk) begin
    if (data_we) begin
      dmem[data_addr[7:2]] <= data_wdata;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_idle(input string phase);
    check_value({phase, "_data_re"}, 32'd0, {31'd0, data_re});
    check_value({phase, "_data_we"}, 32'd0, {31'd0, data_we});
    check_value({phase, "_finish"}, 32'd0, {31'd0, finish});
    check_value({phase, "_instr_addr"}, 32'd0, instr_addr);
  endtask

  task automatic load_input_file();
    int               fd;
    int               code;
    string            tag;
    string            name;
    logic [31:0]      addr;
    logic [31:0]      word;
    logic [8*160-1:0] rest;

    // Unused data words carry their own byte address
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'hC0DE_0000 ^ 32'(i * 4);
    end
    // Byte address as the word, never a legal opcode
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = 32'(i * 4);
    end

    fd = $fopen("verification/program_input.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open verification/program_input.txt");
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "I") begin
        code = $fscanf(fd, "%h %h", addr, word);
        if (code != 2) begin
          abort_run("Malformed instruction line in the stimulus file");
        end
        imem[addr[7:2]] = word;
        prog_words++;
      end else if (tag == "D") begin
        code = $fscanf(fd, "%h %h", addr, word);
        if (code != 2) begin
          abort_run("Malformed data line in the stimulus file");
        end
        dmem[addr[7:2]] = word;
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h %h %s", addr, word, name);
        if (code != 3) begin
          abort_run("Malformed store line in the stimulus file");
        end
        exp_addr[num_stores] = addr;
        exp_data[num_stores] = word;
        exp_name[num_stores] = name;
        num_stores++;
      end else begin
        abort_run({"Unknown tag in the stimulus file: ", tag});
      end
    end
    $fclose(fd);
  endtask

  //##################################################
  // Store checker
  //##################################################
  always @(negedge clk) begin
    if (!reset && data_we) begin
      if (store_count >= num_stores) begin
        abort_run($sformatf("Extra store to address %08h with data %08h",
                            data_addr, data_wdata));
      end else begin
        check_value({exp_name[store_count], "_addr"}, exp_addr[store_count], data_addr);
        check_value({exp_name[store_count], "_data"}, exp_data[store_count], data_wdata);
        store_count++;
      end
    end
  end

  // Watchdog scaled by program length
  initial begin
    @(posedge clk);
    #((4 * prog_words + 100) * CLK_PERIOD);
    abort_run("Watchdog expired, the core never raised finish after EBREAK");
  end

  initial begin
    logic [31:0] halt_pc;

    clk   = 1'b0;
    reset = 1'b1;
    load_input_file();

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_idle("reset_active");
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_idle("reset_release");

    // Program runs until EBREAK reaches write-back
    while (finish !== 1'b1) begin
      @(negedge clk);
    end
    halt_pc = instr_addr;
    repeat (HALT_CYCLES) begin
      @(negedge clk);
      check_value("halt_pc_hold", halt_pc, instr_addr);
      check_value("halt_finish_hold", 32'd1, {31'd0, finish});
    end
    check_value("store_count", 32'(num_stores), 32'(store_count));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* verification/program_input.txt */
# I <byte address> <instruction>, D <byte address> <data word>, all hex
# S <store address> <store data> <test name>, in the order the stores happen
D 40 12345678 # word read by the load
I 00 06400093 # addi x1, x0, 100
I 04 FF908113 # addi x2, x1, -7
I 08 002081B3 # add  x3, x1, x2
I 0C 40118233 # sub  x4, x3, x1
I 10 003242B3 # xor  x5, x4, x3
I 14 0022E333 # or   x6, x5, x2
I 18 003373B3 # and  x7, x6, x3
I 1C 40308433 # sub  x8, x1, x3
I 20 08702023 # sw   x7, 0x80(x0)
I 24 08802223 # sw   x8, 0x84(x0)
I 28 04002483 # lw   x9, 0x40(x0)
I 2C 01148513 # addi x10, x9, 0x11
I 30 08A02423 # sw   x10, 0x88(x0)
I 34 00410663 # beq  x2, x4, +12 taken
I 38 0A102023 # sw   x1, 0xA0(x0) squashed
I 3C 0A102223 # sw   x1, 0xA4(x0) squashed
I 40 00411463 # bne  x2, x4, +8 not taken
I 44 00144663 # blt  x8, x1, +12 taken
I 48 0A102423 # sw   x1, 0xA8(x0) squashed
I 4C 0A102623 # sw   x1, 0xAC(x0) squashed
I 50 00145463 # bge  x8, x1, +8 not taken
I 54 0080D463 # bge  x1, x8, +8 taken
I 58 0A102823 # sw   x1, 0xB0(x0) squashed
I 5C 008005EF # jal  x11, +8
I 60 0A102A23 # sw   x1, 0xB4(x0) squashed
I 64 07400613 # addi x12, x0, 0x74
I 68 000606E7 # jalr x13, 0(x12)
I 6C 0A102C23 # sw   x1, 0xB8(x0) squashed
I 70 0A102E23 # sw   x1, 0xBC(x0) squashed
I 74 08B02623 # sw   x11, 0x8C(x0)
I 78 08D02823 # sw   x13, 0x90(x0)
I 7C 00208463 # beq  x1, x2, +8 not taken
I 80 08602A23 # sw   x6, 0x94(x0)
I 84 00209463 # bne  x1, x2, +8 taken
I 88 0C102023 # sw   x1, 0xC0(x0) squashed
I 8C 00100073 # ebreak
I 90 0C102223 # sw   x1, 0xC4(x0) never reaches write-back
S 80 000000C1 alu_chain_and
S 84 FFFFFFA3 alu_sub_negative
S 88 12345689 load_use
S 8C 00000060 jal_link
S 90 0000006C jalr_link
S 94 000000DD beq_not_taken

/* filelist.f */
logic/riscv_isa_pkg.sv
logic/core_pkg.sv
logic/id_ex_if.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/execute_stage.sv
logic/micro_riscv_top.sv
verification/micro_riscv_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module micro_riscv_tb -f filelist.f \
  && ./obj_dir/Vmicro_riscv_tb | grep "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
